//--- verilog/board_cfg_pkg.sv
`default_nettype none

// Bit positions in the status word and core mode, plus reset timing
package board_cfg_pkg;

    // OSD status word as handed over by the framework
    typedef logic [31:0] status_t;

    // Core mode bits from the core configuration
    typedef logic [6:0] core_mod_t;

    // Status word bits
    localparam int STATUS_ROT_BIT   = 2;   // Set means no rotation wanted
    localparam int STATUS_FLIP_BIT  = 3;   // Screen flip DIP
    localparam int STATUS_PAUSE_BIT = 4;   // OSD pause
    localparam int STATUS_TEST_BIT  = 5;   // Test DIP

    // Core mode bits
    localparam int CORE_VERTICAL_BIT = 0;  // Vertical game
    localparam int CORE_4WAY_BIT     = 1;  // Stick limited to 4 ways

    // Game reset is held for 2**RST_CNT_W cycles
    localparam int RST_CNT_W = 8;

endpackage

`default_nettype wire

//--- verilog/joy_pkg.sv
`default_nettype none

// Joystick word layout shared by the player path
package joy_pkg;

    // Board joystick, active high, 16 bits per player
    typedef logic [15:0] board_joy_t;

    // Word presented to the game
    typedef logic [9:0] game_joy_t;

    // Direction field, bits 3 to 0 of both words
    typedef logic [3:0] dir_t;

    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    // Button positions for a two-button game.
    // Games with more buttons shift these up by buttons-2.
    localparam int BASE_START_BIT = 6;
    localparam int BASE_COIN_BIT  = 7;
    localparam int BASE_PAUSE_BIT = 8;

endpackage

`default_nettype wire

//--- verilog/dip_cfg_if.sv
`default_nettype none

// Decoded settings, all plain levels
interface dip_cfg_if;

    logic rot_control;  // Rotate the stick for a vertical game
    logic flip;         // Screen flipped
    logic osd_pause;    // Pause requested from the menu
    logic en4way;       // 4-way restriction

    modport cfg_src (
        output rot_control, flip, osd_pause, en4way
    );

    modport cfg_player (
        input rot_control, flip, en4way
    );

    modport cfg_ctrl (
        input flip, osd_pause
    );

endinterface

`default_nettype wire

//--- verilog/dip_decode.sv
`default_nettype none

module dip_decode (
    input  wire logic                  clk_sys,
    input  wire logic                  rst,
    input  wire board_cfg_pkg::status_t   status,
    input  wire board_cfg_pkg::core_mod_t core_mod,
    dip_cfg_if.cfg_src                 cfg,
    output logic                       dip_test
);

    import board_cfg_pkg::*;

    logic vertical;
    logic no_rot;

    assign vertical = core_mod[CORE_VERTICAL_BIT];
    assign no_rot   = status[STATUS_ROT_BIT];   // Player asked to keep the screen as is

    // Everything settles one cycle after status or core_mod moves
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg.rot_control <= 1'b0;
            cfg.flip        <= 1'b0;
            cfg.osd_pause   <= 1'b0;
            cfg.en4way      <= 1'b0;
            dip_test        <= 1'b0;
        end else begin
            cfg.rot_control <= vertical & ~no_rot;
            cfg.flip        <= status[STATUS_FLIP_BIT];
            cfg.osd_pause   <= status[STATUS_PAUSE_BIT];
            cfg.en4way      <= core_mod[CORE_4WAY_BIT];
            dip_test        <= status[STATUS_TEST_BIT];
        end
    end

endmodule

`default_nettype wire

//--- verilog/four_way_filter.sv
`default_nettype none

module four_way_filter (
    input  wire logic         clk_sys,
    input  wire logic         rst,
    input  wire logic         en4way,
    input  wire joy_pkg::dir_t joy8,
    output joy_pkg::dir_t     joy4
);

    import joy_pkg::*;

    dir_t last_dir;     // Last direction seen on its own
    logic single;
    logic diagonal;

    assign single   = $onehot(joy8);
    assign diagonal = |joy8 & ~single;

    // Memory follows every clean single press
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_dir <= '0;
        end else if (single) begin
            last_dir <= joy8;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy4 <= '0;
        end else if (!en4way) begin
            joy4 <= joy8;   // 8-way game
        end else if (single) begin
            joy4 <= joy8;
        end else if (diagonal && |(joy8 & last_dir)) begin
            joy4 <= last_dir;   // Stay on the axis already held
        end else begin
            // Diagonal away from the old direction, or released
            joy4 <= '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/player_input.sv
`default_nettype none

module player_input #(
    parameter int buttons    = 2,
    parameter bit active_low = 1'b1
) (
    input  wire logic              clk_sys,
    input  wire logic              rst,
    input  wire joy_pkg::board_joy_t board_joystick,
    dip_cfg_if.cfg_player          cfg,
    output joy_pkg::game_joy_t     game_joystick,
    output logic                   coin,
    output logic                   start,
    output logic                   pause_btn
);

    import joy_pkg::*;

    localparam int start_bit = BASE_START_BIT + buttons - 2;
    localparam int coin_bit  = BASE_COIN_BIT + buttons - 2;
    localparam int pause_bit = BASE_PAUSE_BIT + buttons - 2;

    dir_t       joy4;
    board_joy_t joy_sync;
    game_joy_t  joy_rot;

    four_way_filter u_4way (
        .clk_sys ( clk_sys              ),
        .rst     ( rst                  ),
        .en4way  ( cfg.en4way           ),
        .joy8    ( board_joystick[3:0]  ),
        .joy4    ( joy4                 )
    );

    // Buttons one cycle in, directions two through the filter
    always_ff @(posedge clk_sys) begin
        joy_sync <= {board_joystick[15:4], joy4};
    end

    // Stick turned to follow a rotated screen
    always_comb begin
        joy_rot = joy_sync[9:0];
        if (cfg.rot_control) begin
            if (cfg.flip) begin
                joy_rot[DIR_RIGHT] = joy_sync[DIR_DOWN];
                joy_rot[DIR_LEFT]  = joy_sync[DIR_UP];
                joy_rot[DIR_DOWN]  = joy_sync[DIR_LEFT];
                joy_rot[DIR_UP]    = joy_sync[DIR_RIGHT];
            end else begin
                joy_rot[DIR_RIGHT] = joy_sync[DIR_UP];
                joy_rot[DIR_LEFT]  = joy_sync[DIR_DOWN];
                joy_rot[DIR_DOWN]  = joy_sync[DIR_RIGHT];
                joy_rot[DIR_UP]    = joy_sync[DIR_LEFT];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick <= {$bits(game_joy_t){active_low}};   // Idle level
            coin          <= active_low;
            start         <= active_low;
            pause_btn     <= 1'b0;
        end else begin
            game_joystick <= {$bits(game_joy_t){active_low}} ^ joy_rot;
            coin          <= active_low ^ joy_sync[coin_bit];
            start         <= active_low ^ joy_sync[start_bit];
            pause_btn     <= joy_sync[pause_bit];   // Kept active high
        end
    end

endmodule

`default_nettype wire

//--- verilog/pause_reset_ctrl.sv
`default_nettype none

module pause_reset_ctrl #(
    parameter int rst_cnt_w = board_cfg_pkg::RST_CNT_W
) (
    input  wire logic   clk_sys,
    input  wire logic   rst,
    input  wire logic   downloading,
    input  wire logic   rst_req,
    input  wire logic   pause1,
    input  wire logic   pause2,
    dip_cfg_if.cfg_ctrl cfg,
    output logic        dip_pause,
    output logic        game_rst
);

    logic                 last_pause;
    logic                 last_osd_pause;
    logic                 last_flip;
    logic                 game_pause;
    logic                 game_pause_nxt;
    logic [rst_cnt_w-1:0] rst_cnt;

    logic joy_pause;
    logic pause_rise;
    logic osd_change;
    logic flip_change;
    logic rst_cause;

    assign joy_pause   = pause1 | pause2;   // Either player may pause
    assign pause_rise  = joy_pause & ~last_pause;
    assign osd_change  = cfg.osd_pause ^ last_osd_pause;
    assign flip_change = cfg.flip ^ last_flip;

    always_comb begin
        game_pause_nxt = game_pause;
        if (downloading) begin
            game_pause_nxt = 1'b0;
        end else if (osd_change) begin
            game_pause_nxt = cfg.osd_pause;     // Menu wins over the buttons
        end else if (pause_rise) begin
            game_pause_nxt = ~game_pause;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_pause     <= 1'b0;
            last_osd_pause <= 1'b0;
            last_flip      <= 1'b0;
            game_pause     <= 1'b0;
            dip_pause      <= 1'b1;     // dip_pause is active low
        end else begin
            last_pause     <= joy_pause;
            last_osd_pause <= cfg.osd_pause;
            last_flip      <= cfg.flip;
            game_pause     <= game_pause_nxt;
            dip_pause      <= ~game_pause_nxt;
        end
    end

    // Flipping the screen restarts the game as well
    assign rst_cause = rst | downloading | rst_req | flip_change;

    // Reset stays up until the counter runs through all its values
    always_ff @(posedge clk_sys) begin
        if (rst_cause) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != '1) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/input_board.sv
`default_nettype none

module input_board #(
    parameter int buttons    = 2,
    parameter bit active_low = 1'b1,
    parameter int rst_cnt_w  = board_cfg_pkg::RST_CNT_W
) (
    input  wire logic                    clk_sys,
    input  wire logic                    rst,
    input  wire logic                    rst_req,
    input  wire logic                    downloading,
    input  wire board_cfg_pkg::status_t   status,
    input  wire board_cfg_pkg::core_mod_t core_mod,
    input  wire joy_pkg::board_joy_t      board_joystick1,
    input  wire joy_pkg::board_joy_t      board_joystick2,
    input  wire joy_pkg::board_joy_t      board_joystick3,
    input  wire joy_pkg::board_joy_t      board_joystick4,
    output joy_pkg::game_joy_t           game_joystick1,
    output joy_pkg::game_joy_t           game_joystick2,
    output joy_pkg::game_joy_t           game_joystick3,
    output joy_pkg::game_joy_t           game_joystick4,
    output logic [3:0]                   game_coin,
    output logic [3:0]                   game_start,
    output logic                         dip_test,
    output logic                         dip_flip,
    output logic                         dip_pause,
    output logic                         game_rst
);

    dip_cfg_if cfg ();

    logic pause1;
    logic pause2;

    dip_decode u_dip (
        .clk_sys  ( clk_sys  ),
        .rst      ( rst      ),
        .status   ( status   ),
        .core_mod ( core_mod ),
        .cfg      ( cfg      ),
        .dip_test ( dip_test )
    );

    assign dip_flip = cfg.flip;

    player_input #(.buttons(buttons), .active_low(active_low)) u_player1 (
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .board_joystick ( board_joystick1 ),
        .cfg            ( cfg             ),
        .game_joystick  ( game_joystick1  ),
        .coin           ( game_coin[0]    ),
        .start          ( game_start[0]   ),
        .pause_btn      ( pause1          )
    );

    player_input #(.buttons(buttons), .active_low(active_low)) u_player2 (
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .board_joystick ( board_joystick2 ),
        .cfg            ( cfg             ),
        .game_joystick  ( game_joystick2  ),
        .coin           ( game_coin[1]    ),
        .start          ( game_start[1]   ),
        .pause_btn      ( pause2          )
    );

    // Players 3 and 4 have no pause button
    player_input #(.buttons(buttons), .active_low(active_low)) u_player3 (
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .board_joystick ( board_joystick3 ),
        .cfg            ( cfg             ),
        .game_joystick  ( game_joystick3  ),
        .coin           ( game_coin[2]    ),
        .start          ( game_start[2]   ),
        .pause_btn      (                 )
    );

    player_input #(.buttons(buttons), .active_low(active_low)) u_player4 (
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .board_joystick ( board_joystick4 ),
        .cfg            ( cfg             ),
        .game_joystick  ( game_joystick4  ),
        .coin           ( game_coin[3]    ),
        .start          ( game_start[3]   ),
        .pause_btn      (                 )
    );

    pause_reset_ctrl #(.rst_cnt_w(rst_cnt_w)) u_ctrl (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .pause1      ( pause1      ),
        .pause2      ( pause2      ),
        .cfg         ( cfg         ),
        .dip_pause   ( dip_pause   ),
        .game_rst    ( game_rst    )
    );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`default_nettype none

module clock_gen #(
    parameter int half_period = 5   // In ns, 10 ns period
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

`default_nettype wire

//--- bench/input_board_asserts.sv
`default_nettype none

module input_board_asserts (
    input wire logic clk_sys,
    input wire logic rst,
    input wire logic rst_req,
    input wire logic downloading,
    input wire logic dip_pause,
    input wire logic game_rst
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;     // Read by the testbench at the end of the run

    a_rst_holds_game_rst: assert property (@(posedge clk_sys) rst |=> game_rst)
        else begin
            fail_count++;
            $error("game_rst low while rst was high");
        end

    a_rst_req_starts_reset: assert property (@(posedge clk_sys) rst_req |=> game_rst)
        else begin
            fail_count++;
            $error("game_rst did not follow rst_req");
        end

    // Loading a new game always unpauses
    a_download_clears_pause: assert property (@(posedge clk_sys) downloading |=> dip_pause)
        else begin
            fail_count++;
            $error("dip_pause low in the cycle after downloading");
        end

endmodule

bind pause_reset_ctrl input_board_asserts u_asserts (
    .clk_sys     ( clk_sys     ),
    .rst         ( rst         ),
    .rst_req     ( rst_req     ),
    .downloading ( downloading ),
    .dip_pause   ( dip_pause   ),
    .game_rst    ( game_rst    )
);

`default_nettype wire

//--- bench/tb_input_board.sv
`default_nettype none

module tb_input_board;

    timeunit 1ns;
    timeprecision 100ps;

    import board_cfg_pkg::*;
    import joy_pkg::*;

    localparam int hold_cycles = 4;     // Longest path incl. settings change
    localparam int n_rot       = 40;
    localparam int n_4way      = 40;
    localparam int n_btn       = 20;
    localparam int n_pause     = 12;
    localparam int stretch     = 2 ** RST_CNT_W;

    localparam int len_reset = 10;
    localparam int len_joy   = (n_rot + n_4way + n_btn) * hold_cycles;
    localparam int len_pause = n_pause * 8 + 60;
    localparam int len_rst   = 3 * (stretch + 4);  // Wait plus two stretches
    localparam int max_cycles = (len_reset + len_joy + len_pause + len_rst) * 3 / 2;

    logic       clk_sys;
    logic       rst;
    logic       rst_req;
    logic       downloading;
    status_t    status;
    core_mod_t  core_mod;
    board_joy_t joy_in [4];
    game_joy_t  joy_out [4];
    logic [3:0] game_coin;
    logic [3:0] game_start;
    logic       dip_test;
    logic       dip_flip;
    logic       dip_pause;
    logic       game_rst;

    dir_t mem [4];          // Model of each player's remembered direction
    logic exp_pause;
    int   cycle_cnt = 0;

    clock_gen u_clk (.clk(clk_sys));

    input_board input_board_i (
        .clk_sys         ( clk_sys     ),
        .rst             ( rst         ),
        .rst_req         ( rst_req     ),
        .downloading     ( downloading ),
        .status          ( status      ),
        .core_mod        ( core_mod    ),
        .board_joystick1 ( joy_in[0]   ),
        .board_joystick2 ( joy_in[1]   ),
        .board_joystick3 ( joy_in[2]   ),
        .board_joystick4 ( joy_in[3]   ),
        .game_joystick1  ( joy_out[0]  ),
        .game_joystick2  ( joy_out[1]  ),
        .game_joystick3  ( joy_out[2]  ),
        .game_joystick4  ( joy_out[3]  ),
        .game_coin       ( game_coin   ),
        .game_start      ( game_start  ),
        .dip_test        ( dip_test    ),
        .dip_flip        ( dip_flip    ),
        .dip_pause       ( dip_pause   ),
        .game_rst        ( game_rst    )
    );

    task automatic fail_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_joy(string name, game_joy_t got, game_joy_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_vec4(string name, logic [3:0] got, logic [3:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic step(int n);
        repeat (n) @(negedge clk_sys);
    endtask

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: tests did not complete within %0d clock cycles", max_cycles);
            fail_run();
        end else if (input_board_i.u_ctrl.u_asserts.fail_count != 0) begin
            $display("bound assertion failed before cycle %0d", cycle_cnt);
            fail_run();
        end
    end

    // Screen rotation seen from the player's side
    function automatic dir_t rotate_dirs(dir_t d, logic rot, logic flp);
        dir_t r;
        r = d;
        if (rot && !flp) begin
            r[DIR_RIGHT] = d[DIR_UP];
            r[DIR_LEFT]  = d[DIR_DOWN];
            r[DIR_DOWN]  = d[DIR_RIGHT];
            r[DIR_UP]    = d[DIR_LEFT];
        end else if (rot) begin
            r[DIR_RIGHT] = d[DIR_DOWN];
            r[DIR_LEFT]  = d[DIR_UP];
            r[DIR_DOWN]  = d[DIR_LEFT];
            r[DIR_UP]    = d[DIR_RIGHT];
        end
        return r;
    endfunction

    // Held input, so one call per hold is enough
    function automatic dir_t four_way_dir(int p, dir_t joy8, logic en);
        dir_t out;
        logic single;
        single = ($countones(joy8) == 1);
        if (!en || single)
            out = joy8;
        else if (joy8 != '0 && (joy8 & mem[p]) != '0)
            out = mem[p];
        else
            out = '0;
        if (single)
            mem[p] = joy8;
        return out;
    endfunction

    function automatic game_joy_t expected_joy(board_joy_t b, dir_t d, logic rot, logic flp);
        game_joy_t w;
        w = {b[9:4], rotate_dirs(d, rot, flp)};
        return ~w;      // Default build has active-low game inputs
    endfunction

    function automatic dir_t random_dirs();
        int a;
        int b;
        a = $urandom_range(0, 3);
        b = (a + $urandom_range(1, 3)) % 4;
        case ($urandom_range(0, 3))
            0: return '0;
            3: return dir_t'((1 << a) | (1 << b));  // Diagonal or opposite pair
            default: return dir_t'(1 << a);
        endcase
    endfunction

    task automatic check_players();
        logic       rot;
        logic       flp;
        logic [3:0] exp_coin;
        logic [3:0] exp_start;
        dir_t       d;
        rot = core_mod[CORE_VERTICAL_BIT] & ~status[STATUS_ROT_BIT];
        flp = status[STATUS_FLIP_BIT];
        for (int p = 0; p < 4; p++) begin
            d = four_way_dir(p, joy_in[p][3:0], core_mod[CORE_4WAY_BIT]);
            check_joy($sformatf("game_joystick%0d", p + 1), joy_out[p],
                      expected_joy(joy_in[p], d, rot, flp));
            exp_coin[p]  = ~joy_in[p][BASE_COIN_BIT];
            exp_start[p] = ~joy_in[p][BASE_START_BIT];
        end
        check_vec4("game_coin", game_coin, exp_coin);
        check_vec4("game_start", game_start, exp_start);
        check_bit("dip_test", dip_test, status[STATUS_TEST_BIT]);
        check_bit("dip_flip", dip_flip, status[STATUS_FLIP_BIT]);
    endtask

    task automatic run_joy_test(int n, logic en4);
        for (int i = 0; i < n; i++) begin
            status   = status_t'($urandom);
            core_mod = core_mod_t'($urandom);
            core_mod[CORE_4WAY_BIT] = en4;
            for (int p = 0; p < 4; p++) begin
                joy_in[p] = board_joy_t'($urandom);
                if (en4)
                    joy_in[p][3:0] = random_dirs();
            end
            step(hold_cycles);
            check_players();
        end
    endtask

    task automatic run_button_test();
        for (int i = 0; i < n_btn; i++) begin
            for (int p = 0; p < 4; p++) begin
                joy_in[p] = '0;
                joy_in[p][BASE_COIN_BIT]  = $urandom_range(0, 1);
                joy_in[p][BASE_START_BIT] = $urandom_range(0, 1);
            end
            step(hold_cycles);
            check_players();
        end
    endtask

    // which bit 0 is player 1, bit 1 is player 2
    task automatic press_pause(int which);
        joy_in[0][BASE_PAUSE_BIT] = which[0];
        joy_in[1][BASE_PAUSE_BIT] = which[1];
        step(2);
        joy_in[0][BASE_PAUSE_BIT] = 1'b0;
        joy_in[1][BASE_PAUSE_BIT] = 1'b0;
        step(4);
        exp_pause = ~exp_pause;
        check_bit("dip_pause", dip_pause, ~exp_pause);
    endtask

    task automatic pulse_download();
        downloading = 1'b1;
        step(1);
        downloading = 1'b0;
        step(3);
        exp_pause = 1'b0;
        check_bit("dip_pause", dip_pause, ~exp_pause);
    endtask

    task automatic run_pause_test();
        status   = '0;
        core_mod = '0;
        for (int p = 0; p < 4; p++)
            joy_in[p] = '0;
        step(hold_cycles);
        pulse_download();
        for (int i = 0; i < n_pause; i++)
            press_pause($urandom_range(1, 3));
        // Menu pause forces the state either way
        status[STATUS_PAUSE_BIT] = 1'b1;
        step(hold_cycles);
        exp_pause = 1'b1;
        check_bit("dip_pause", dip_pause, ~exp_pause);
        press_pause(1);
        press_pause(2);
        status[STATUS_PAUSE_BIT] = 1'b0;
        step(hold_cycles);
        exp_pause = 1'b0;
        check_bit("dip_pause", dip_pause, ~exp_pause);
        press_pause(3);
        pulse_download();
    endtask

    // Called right after the last cause cycle
    task automatic check_stretch();
        for (int k = 0; k < stretch; k++) begin
            check_bit("game_rst", game_rst, 1'b1);
            step(1);
        end
        check_bit("game_rst", game_rst, 1'b0);
    endtask

    task automatic run_reset_test();
        while (game_rst)
            step(1);
        rst_req = 1'b1;
        step(1);
        rst_req = 1'b0;
        check_stretch();
        status[STATUS_FLIP_BIT] = ~status[STATUS_FLIP_BIT];
        step(2);        // Decoder register, then the flip edge
        check_stretch();
    endtask

    initial begin
        void'($urandom(32'he003_668a));
        rst         = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        status      = '0;
        core_mod    = '0;
        exp_pause   = 1'b0;
        for (int p = 0; p < 4; p++) begin
            joy_in[p] = '0;
            mem[p]    = '0;
        end
        step(8);
        rst = 1'b0;
        check_bit("game_rst", game_rst, 1'b1);
        check_bit("dip_pause", dip_pause, 1'b1);
        check_vec4("game_coin", game_coin, 4'hf);
        check_vec4("game_start", game_start, 4'hf);

        run_joy_test(n_rot, 1'b0);
        run_joy_test(n_4way, 1'b1);
        run_button_test();
        run_pause_test();
        run_reset_test();

        if (input_board_i.u_ctrl.u_asserts.fail_count != 0) begin
            $display("bound assertions failed during the run");
            fail_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- all.f
verilog/board_cfg_pkg.sv
verilog/joy_pkg.sv
verilog/dip_cfg_if.sv
verilog/dip_decode.sv
verilog/four_way_filter.sv
verilog/player_input.sv
verilog/pause_reset_ctrl.sv
verilog/input_board.sv
bench/clock_gen.sv
bench/input_board_asserts.sv
bench/tb_input_board.sv
